// ==== Makefile ====
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard logic/*.sv tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '^\*\* PASS \*\*$$' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
logic/cache_pkg.sv
logic/cache_tag_store.sv
logic/cache_data_store.sv
logic/cache_controller.sv
logic/l2_cache.sv
tests/tb_clock.sv
tests/slow_mem_model.sv
tests/cache_tb.sv

// ==== logic/cache_controller.sv ====
// Miss-handling FSM; drives stall, tag/data strobes and the line-wide memory request
`timescale 1ns/1ps
`default_nettype none

module cache_controller (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  read,
    input  logic                  write,
    input  logic                  hit,
    input  logic                  victim_dirty,
    input  cache_pkg::tag_t       victim_tag,
    input  cache_pkg::set_idx_t   set,
    input  cache_pkg::proc_addr_t addr,
    input  cache_pkg::line_t      victim_line,
    input  logic                  mem_ready,
    output logic                  stall,
    output logic                  fill,
    output logic                  fill_dirty,
    output logic                  write_hit,
    output logic                  touch,
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::mem_addr_t  mem_addr,
    output cache_pkg::line_t      mem_wdata
);

    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t state_nxt;

    logic                 req;
    logic                 miss;
    logic                 in_idle;
    logic                 in_evict;
    logic                 in_fill;
    logic                 start_miss;
    cache_pkg::mem_addr_t req_line_addr;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------
    assign req           = read || write;
    assign miss          = req && !hit;
    assign in_idle       = (state == cache_pkg::st_idle);
    assign in_evict      = (state == cache_pkg::st_evict_for_read) ||
                           (state == cache_pkg::st_evict_for_write);
    assign in_fill       = (state == cache_pkg::st_fill_for_read) ||
                           (state == cache_pkg::st_fill_for_write);
    assign start_miss    = in_idle && miss;
    assign req_line_addr = addr[cache_pkg::proc_addr_w-1:cache_pkg::off_w];

    // Hit path and stall are combinational
    assign stall      = miss;
    assign touch      = in_idle && req && hit;
    assign write_hit  = in_idle && write && hit;
    assign fill       = in_fill && mem_ready;  // Line valid on mem_rdata this cycle
    assign fill_dirty = (state == cache_pkg::st_fill_for_write);

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::st_idle: begin
                if (miss && read) begin
                    state_nxt = victim_dirty ? cache_pkg::st_evict_for_read
                                             : cache_pkg::st_fill_for_read;
                end else if (miss) begin
                    state_nxt = victim_dirty ? cache_pkg::st_evict_for_write
                                             : cache_pkg::st_fill_for_write;
                end
            end
            cache_pkg::st_evict_for_read: begin
                if (mem_ready) state_nxt = cache_pkg::st_fill_for_read;
            end
            cache_pkg::st_evict_for_write: begin
                if (mem_ready) state_nxt = cache_pkg::st_fill_for_write;
            end
            cache_pkg::st_fill_for_read,
            cache_pkg::st_fill_for_write: begin
                if (mem_ready) state_nxt = cache_pkg::st_idle;
            end
            default: state_nxt = cache_pkg::st_idle;
        endcase
    end

    // --------------------------------------------------
    // State and memory request
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= cache_pkg::st_idle;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            state <= state_nxt;
            if (start_miss) begin
                mem_write <= victim_dirty;   // Write back first if needed
                mem_read  <= !victim_dirty;
            end else if (in_evict && mem_ready) begin
                mem_write <= 1'b0;
                mem_read  <= 1'b1;
            end else if (in_fill && mem_ready) begin
                mem_read  <= 1'b0;
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (start_miss) begin
            mem_addr  <= victim_dirty ? {victim_tag, set} : req_line_addr;
            mem_wdata <= victim_line;
        end else if (in_evict && mem_ready) begin
            mem_addr  <= req_line_addr;  // Now fetch the requested line
        end
    end

    a_no_read_and_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write)
    );

    // Request and address hold until memory answers
    a_read_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_read && !mem_ready |=> mem_read && $stable(mem_addr)
    );

    a_write_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_write && !mem_ready |=> mem_write && $stable(mem_addr) && $stable(mem_wdata)
    );

endmodule

`default_nettype wire

// ==== logic/cache_data_store.sv ====
// Line storage for both ways; word read and write on hits, whole-line fill from memory
`timescale 1ns/1ps
`default_nettype none

module cache_data_store (
    input  logic                 clk,
    input  cache_pkg::set_idx_t  set,
    input  cache_pkg::word_off_t offset,
    input  logic                 hit_way,
    input  logic                 victim_way,
    input  logic                 write_hit,
    input  cache_pkg::word_t     wdata,
    input  logic                 fill,
    input  cache_pkg::line_t     mem_rdata,
    output cache_pkg::word_t     rdata,
    output cache_pkg::line_t     victim_line
);

    // Two lines per set, indexed [set][way]
    cache_pkg::line_t lines [cache_pkg::num_sets][2];

    cache_pkg::line_t hit_line;

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    assign hit_line    = lines[set][hit_way];
    assign rdata       = hit_line[offset * cache_pkg::word_w +: cache_pkg::word_w];
    assign victim_line = lines[set][victim_way];  // For write-back

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    // Fill and hit write never coincide: fill only comes after a miss
    always_ff @(posedge clk) begin
        if (fill) begin
            lines[set][victim_way] <= mem_rdata;
        end else if (write_hit) begin
            lines[set][hit_way][offset * cache_pkg::word_w +: cache_pkg::word_w] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_pkg.sv ====
// Shared cache geometry, width types and controller states, referenced by scoped names
`default_nettype none

package cache_pkg;

    // --------------------------------------------------
    // Geometry
    // --------------------------------------------------
    localparam int word_w         = 32;
    localparam int words_per_line = 4;
    localparam int line_w         = word_w * words_per_line;  // 128
    localparam int num_sets       = 4;
    localparam int set_w          = $clog2(num_sets);
    localparam int off_w          = $clog2(words_per_line);

    // Word address from the processor, line address to memory
    localparam int proc_addr_w    = 30;
    localparam int tag_w          = proc_addr_w - set_w - off_w;  // 26
    localparam int mem_addr_w     = proc_addr_w - off_w;          // 28

    // --------------------------------------------------
    // Width types
    // --------------------------------------------------
    typedef logic [word_w-1:0]      word_t;
    typedef logic [line_w-1:0]      line_t;
    typedef logic [proc_addr_w-1:0] proc_addr_t;  // Tag, set, offset
    typedef logic [mem_addr_w-1:0]  mem_addr_t;   // Tag, set
    typedef logic [tag_w-1:0]       tag_t;
    typedef logic [set_w-1:0]       set_idx_t;
    typedef logic [off_w-1:0]       word_off_t;

    // --------------------------------------------------
    // Miss handling FSM
    // --------------------------------------------------
    // Evict states write back the dirty victim first
    typedef enum logic [2:0] {
        st_idle,
        st_evict_for_read,
        st_fill_for_read,
        st_evict_for_write,
        st_fill_for_write
    } cache_state_t;

endpackage

`default_nettype wire

// ==== logic/cache_tag_store.sv ====
// Valid, dirty, tag and LRU bookkeeping for both ways; gives hit and victim info to the cache
`timescale 1ns/1ps
`default_nettype none

module cache_tag_store (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::set_idx_t set,
    input  cache_pkg::tag_t     tag,
    input  logic                fill,        // Install tag in victim way
    input  logic                fill_dirty,
    input  logic                write_hit,   // Mark hit way dirty
    input  logic                touch,       // Hit way becomes most recent
    output logic                hit,
    output logic                hit_way,
    output logic                victim_way,
    output logic                victim_dirty,
    output cache_pkg::tag_t     victim_tag
);

    // --------------------------------------------------
    // State, indexed [way][set]
    // --------------------------------------------------
    logic [1:0][cache_pkg::num_sets-1:0] valid;
    logic [1:0][cache_pkg::num_sets-1:0] dirty;
    logic [cache_pkg::num_sets-1:0]      lru;    // Way to replace next
    cache_pkg::tag_t                     tags [2][cache_pkg::num_sets];

    logic hit0;
    logic hit1;

    // --------------------------------------------------
    // Lookup
    // --------------------------------------------------
    assign hit0 = valid[0][set] && (tags[0][set] == tag);
    assign hit1 = valid[1][set] && (tags[1][set] == tag);

    assign hit          = hit0 || hit1;
    assign hit_way      = hit1;
    assign victim_way   = lru[set];
    assign victim_dirty = dirty[victim_way][set];  // Dirty only ever set on a valid line
    assign victim_tag   = tags[victim_way][set];

    // --------------------------------------------------
    // Updates
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (fill) begin
                valid[victim_way][set] <= 1'b1;
                dirty[victim_way][set] <= fill_dirty;
            end
            if (write_hit) begin
                dirty[hit_way][set] <= 1'b1;
            end
            if (touch) begin
                lru[set] <= ~hit_way;  // Other way is now least recent
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[victim_way][set] <= tag;
        end
    end

    // Fills only target the victim after a miss, so one tag never lives in both ways
    a_one_way_hits: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(hit0 && hit1)
    );

endmodule

`default_nettype wire

// ==== logic/l2_cache.sv ====
// Top of the two-way write-back cache; connect a word requester and a slow line memory
`timescale 1ns/1ps
`default_nettype none

module l2_cache (
    input  logic                  clk,
    input  logic                  rst_n,
    // Processor side
    input  logic                  read,
    input  logic                  write,
    input  cache_pkg::proc_addr_t addr,
    input  cache_pkg::word_t      wdata,
    output logic                  stall,
    output cache_pkg::word_t      rdata,
    // Memory side
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::mem_addr_t  mem_addr,
    output cache_pkg::line_t      mem_wdata,
    input  cache_pkg::line_t      mem_rdata,
    input  logic                  mem_ready
);

    // --------------------------------------------------
    // Address fields
    // --------------------------------------------------
    cache_pkg::tag_t      req_tag;
    cache_pkg::set_idx_t  req_set;
    cache_pkg::word_off_t req_off;

    assign req_tag = addr[cache_pkg::proc_addr_w-1 -: cache_pkg::tag_w];
    assign req_set = addr[cache_pkg::off_w +: cache_pkg::set_w];
    assign req_off = addr[cache_pkg::off_w-1:0];

    logic             hit;
    logic             hit_way;
    logic             victim_way;
    logic             victim_dirty;
    cache_pkg::tag_t  victim_tag;
    cache_pkg::line_t victim_line;
    logic             fill;
    logic             fill_dirty;
    logic             write_hit;
    logic             touch;

    cache_tag_store tag_store_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .set          (req_set),
        .tag          (req_tag),
        .fill         (fill),
        .fill_dirty   (fill_dirty),
        .write_hit    (write_hit),
        .touch        (touch),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_data_store data_store_i (
        .clk          (clk),
        .set          (req_set),
        .offset       (req_off),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .write_hit    (write_hit),
        .wdata        (wdata),
        .fill         (fill),
        .mem_rdata    (mem_rdata),
        .rdata        (rdata),
        .victim_line  (victim_line)
    );

    cache_controller controller_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .read         (read),
        .write        (write),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .set          (req_set),
        .addr         (addr),
        .victim_line  (victim_line),
        .mem_ready    (mem_ready),
        .stall        (stall),
        .fill         (fill),
        .fill_dirty   (fill_dirty),
        .write_hit    (write_hit),
        .touch        (touch),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

endmodule

`default_nettype wire

// ==== tests/cache_tb.sv ====
// Directed testbench for the two-way cache; run as top with the slow memory model attached
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    localparam int timeout_cycles = 40;  // Two transfers of up to 4 cycles, plus margin

    logic                  clk;
    logic                  rst_n;
    logic                  read;
    logic                  write;
    cache_pkg::proc_addr_t addr;
    cache_pkg::word_t      wdata;
    logic                  stall;
    cache_pkg::word_t      rdata;
    logic                  mem_read;
    logic                  mem_write;
    cache_pkg::mem_addr_t  mem_addr;
    cache_pkg::line_t      mem_wdata;
    cache_pkg::line_t      mem_rdata;
    logic                  mem_ready;

    int checks;
    int errors;
    int reads_done;
    int writes_done;
    cache_pkg::mem_addr_t last_read_addr;
    cache_pkg::mem_addr_t last_write_addr;
    cache_pkg::line_t     last_write_line;

    cache_pkg::word_t shadow [cache_pkg::proc_addr_t];  // Word values the program expects

    tb_clock clock_i (.clk(clk), .rst_n(rst_n));

    l2_cache l2_cache_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .read      (read),
        .write     (write),
        .addr      (addr),
        .wdata     (wdata),
        .stall     (stall),
        .rdata     (rdata),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    slow_mem_model mem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    // --------------------------------------------------
    // Memory traffic monitor
    // --------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_read && mem_write) begin
                errors++;
                $display("Error at %0t: mem_read and mem_write are high together", $time);
            end
            if (mem_ready && mem_read) begin
                reads_done++;
                last_read_addr = mem_addr;
            end
            if (mem_ready && mem_write) begin
                writes_done++;
                last_write_addr = mem_addr;
                last_write_line = mem_wdata;
            end
        end
    end

    // --------------------------------------------------
    // Expected values
    // --------------------------------------------------
    function automatic cache_pkg::proc_addr_t make_addr(input cache_pkg::tag_t t,
            input cache_pkg::set_idx_t s, input cache_pkg::word_off_t o);
        return {t, s, o};
    endfunction

    function automatic cache_pkg::mem_addr_t line_of(input cache_pkg::proc_addr_t a);
        return a[cache_pkg::proc_addr_w-1:cache_pkg::off_w];  // Tag and set
    endfunction

    function automatic cache_pkg::word_t expected_word(input cache_pkg::proc_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return {a, 2'b11} ^ 32'h5a00_00a5;  // Memory contents before any write
    endfunction

    function automatic cache_pkg::line_t expected_line(input cache_pkg::mem_addr_t la);
        cache_pkg::line_t l;
        int               i;
        for (i = 0; i < cache_pkg::words_per_line; i++) begin
            l[i*cache_pkg::word_w +: cache_pkg::word_w] = expected_word({la, i[1:0]});
        end
        return l;
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input cache_pkg::word_t got,
            input cache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input cache_pkg::line_t got,
            input cache_pkg::line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mem_addr(input string name, input cache_pkg::mem_addr_t got,
            input cache_pkg::mem_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Line transfers since a snapshot of the monitor counts
    task automatic check_traffic(input string what, input int r0, input int w0,
            input int exp_reads, input int exp_writes);
        checks++;
        if (reads_done - r0 != exp_reads || writes_done - w0 != exp_writes) begin
            errors++;
            $display("Error at %0t: %s saw %0d reads and %0d writes, expected %0d and %0d",
                     $time, what, reads_done - r0, writes_done - w0, exp_reads, exp_writes);
        end
    endtask

    // --------------------------------------------------
    // Run control and bus access
    // --------------------------------------------------
    task automatic end_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            errors++;
            end_run();
        end
    endtask

    task automatic wait_stall_low(input string what);
        int n;
        n = 0;
        while (stall && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (stall) begin
            $display("Timeout: stall stayed high for %0d cycles during a %s", n, what);
            errors++;
            end_run();
        end
    endtask

    // One request, held until stall falls; completes at the following edge
    task automatic access(input logic is_write, input cache_pkg::proc_addr_t a,
            input cache_pkg::word_t d, output cache_pkg::word_t data,
            output logic first_stall, output logic first_req);
        @(posedge clk);
        read  <= !is_write;
        write <= is_write;
        addr  <= a;
        wdata <= d;
        @(negedge clk);
        first_stall = stall;
        first_req   = mem_read || mem_write;  // Request starts one cycle after the miss
        wait_stall_low(is_write ? "write" : "read");
        data = rdata;
        @(posedge clk);
        read  <= 1'b0;
        write <= 1'b0;
        if (is_write) begin
            shadow[a] = d;
        end
        // A finished access leaves no request behind, hits raise none at all
        @(negedge clk);
        check_bit("mem_read or mem_write after access", mem_read || mem_write, 1'b0);
    endtask

    // Read and compare against the shadow, return whether it missed
    task automatic read_check(input string name, input cache_pkg::proc_addr_t a,
            output logic missed);
        cache_pkg::word_t data;
        logic             first_req;
        access(1'b0, a, '0, data, missed, first_req);
        check_word(name, data, expected_word(a));
    endtask

    task automatic write_word(input cache_pkg::proc_addr_t a, input cache_pkg::word_t d,
            output logic missed);
        cache_pkg::word_t data;
        logic             first_req;
        access(1'b1, a, d, data, missed, first_req);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic outputs_after_reset();
        @(negedge clk);
        check_bit("mem_read after reset", mem_read, 1'b0);
        check_bit("mem_write after reset", mem_write, 1'b0);
        check_bit("stall with no request", stall, 1'b0);
    endtask

    task automatic read_miss_then_hit();
        cache_pkg::proc_addr_t a;
        cache_pkg::word_t      data;
        logic                  first_stall;
        logic                  first_req;
        int                    r0;
        int                    w0;
        a  = make_addr(26'h10, 2'd0, 2'd1);
        r0 = reads_done;
        w0 = writes_done;
        access(1'b0, a, '0, data, first_stall, first_req);
        check_bit("stall on read miss", first_stall, 1'b1);
        check_bit("mem request in miss cycle", first_req, 1'b0);
        check_traffic("clean read miss", r0, w0, 1, 0);
        check_mem_addr("mem_addr of line read", last_read_addr, line_of(a));
        check_word("rdata after read miss", data, expected_word(a));
        // Same line again, two words
        r0 = reads_done;
        read_check("rdata on read hit", a, first_stall);
        check_bit("stall on read hit", first_stall, 1'b0);
        read_check("rdata on hit to other word", make_addr(26'h10, 2'd0, 2'd3), first_stall);
        check_bit("stall on other word hit", first_stall, 1'b0);
        check_traffic("read hits", r0, w0, 0, 0);
    endtask

    task automatic write_hit_and_miss();
        cache_pkg::proc_addr_t a;
        cache_pkg::proc_addr_t b;
        logic                  missed;
        int                    r0;
        int                    w0;
        a  = make_addr(26'h10, 2'd0, 2'd2);
        r0 = reads_done;
        w0 = writes_done;
        write_word(a, 32'hcafe_0001, missed);
        check_bit("stall on write hit", missed, 1'b0);
        read_check("rdata after write hit", a, missed);
        check_bit("stall on read of written word", missed, 1'b0);
        check_traffic("write hit and read", r0, w0, 0, 0);
        // Write miss allocates the line
        b = make_addr(26'h20, 2'd1, 2'd3);
        write_word(b, 32'hcafe_0002, missed);
        check_bit("stall on write miss", missed, 1'b1);
        check_traffic("write miss", r0, w0, 1, 0);
        check_mem_addr("mem_addr of write miss fetch", last_read_addr, line_of(b));
        read_check("rdata after write miss", b, missed);
        check_bit("stall on read after write miss", missed, 1'b0);
        read_check("rdata of unwritten word", make_addr(26'h20, 2'd1, 2'd0), missed);
        check_traffic("reads after write miss", r0, w0, 1, 0);
    endtask

    task automatic dirty_eviction();
        cache_pkg::proc_addr_t a;
        logic                  missed;
        int                    r0;
        int                    w0;
        a  = make_addr(26'h30, 2'd2, 2'd1);
        write_word(a, 32'hd1e7_0030, missed);
        r0 = reads_done;
        w0 = writes_done;
        read_check("rdata of second tag", make_addr(26'h31, 2'd2, 2'd0), missed);
        check_traffic("second tag in set", r0, w0, 1, 0);
        // Third tag evicts the dirty least recent line
        r0 = reads_done;
        read_check("rdata of third tag", make_addr(26'h32, 2'd2, 2'd2), missed);
        check_traffic("dirty eviction", r0, w0, 1, 1);
        check_mem_addr("mem_addr of write-back", last_write_addr, line_of(a));
        check_line("mem_wdata of write-back", last_write_line, expected_line(line_of(a)));
        check_mem_addr("mem_addr of fetch after write-back", last_read_addr,
                       line_of(make_addr(26'h32, 2'd2, 2'd2)));
        read_check("written word after eviction", a, missed);
        check_bit("stall on evicted line", missed, 1'b1);
    endtask

    task automatic lru_replacement();
        logic missed;
        int   r0;
        int   w0;
        read_check("rdata of line A", make_addr(26'h40, 2'd3, 2'd0), missed);
        read_check("rdata of line B", make_addr(26'h41, 2'd3, 2'd1), missed);
        read_check("rdata of line A again", make_addr(26'h40, 2'd3, 2'd2), missed);
        check_bit("stall on line A reuse", missed, 1'b0);
        r0 = reads_done;
        w0 = writes_done;
        read_check("rdata of line C", make_addr(26'h42, 2'd3, 2'd3), missed);
        check_traffic("line C replaces line B", r0, w0, 1, 0);
        read_check("rdata of line A after C", make_addr(26'h40, 2'd3, 2'd1), missed);
        check_bit("stall on line A after C", missed, 1'b0);
        r0 = reads_done;
        read_check("rdata of line B after C", make_addr(26'h41, 2'd3, 2'd1), missed);
        check_bit("stall on line B after C", missed, 1'b1);
        check_traffic("line B fetched again", r0, w0, 1, 0);
        check_mem_addr("mem_addr of line B", last_read_addr,
                       line_of(make_addr(26'h41, 2'd3, 2'd1)));
    endtask

    // Three tags in one set keep missing, so every access sees a fresh latency
    task automatic latency_sweep();
        cache_pkg::proc_addr_t a;
        logic                  missed;
        int                    i;
        for (i = 0; i < 12; i++) begin
            a = make_addr(cache_pkg::tag_t'(50 + i % 3), 2'd1, cache_pkg::word_off_t'(i % 4));
            if (i % 2 == 0) begin
                write_word(a, {16'hbeef, 16'(i)}, missed);
            end else begin
                read_check("rdata in latency sweep", a, missed);
            end
        end
        for (i = 0; i < 12; i += 2) begin
            a = make_addr(cache_pkg::tag_t'(50 + i % 3), 2'd1, cache_pkg::word_off_t'(i % 4));
            read_check("rdata of swept write", a, missed);
        end
    endtask

    initial begin
        read            = 1'b0;
        write           = 1'b0;
        addr            = '0;
        wdata           = '0;
        checks          = 0;
        errors          = 0;
        reads_done      = 0;
        writes_done     = 0;
        last_read_addr  = '0;
        last_write_addr = '0;
        last_write_line = '0;
        wait_reset_release();
        outputs_after_reset();
        read_miss_then_hit();
        write_hit_and_miss();
        dirty_eviction();
        lru_replacement();
        latency_sweep();
        end_run();
    end

endmodule

`default_nettype wire

// ==== tests/slow_mem_model.sv ====
// Line-wide memory for the testbench; answers each request after 1 to 4 cycles with a ready pulse
`timescale 1ns/1ps
`default_nettype none

module slow_mem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  cache_pkg::mem_addr_t mem_addr,
    input  cache_pkg::line_t     mem_wdata,
    output cache_pkg::line_t     mem_rdata,
    output logic                 mem_ready
);

    cache_pkg::line_t stored [cache_pkg::mem_addr_t];  // Lines written back so far

    logic [31:0] lcg_state;
    logic [31:0] lcg_step;
    logic        busy;
    logic [1:0]  wait_left;  // Extra cycles before ready

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Untouched lines hold a pattern built from the full word address
    function automatic cache_pkg::line_t line_value(input cache_pkg::mem_addr_t a);
        cache_pkg::line_t l;
        int               i;
        if (stored.exists(a)) begin
            return stored[a];
        end
        for (i = 0; i < cache_pkg::words_per_line; i++) begin
            l[i*cache_pkg::word_w +: cache_pkg::word_w] = {a, i[1:0], 2'b11} ^ 32'h5a00_00a5;
        end
        return l;
    endfunction

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
    end

    // --------------------------------------------------
    // Request handling
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            lcg_state <= 32'h19e7;
            busy      <= 1'b0;
            wait_left <= 2'd0;
            mem_ready <= 1'b0;
            mem_rdata <= '0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;  // Request still old at this edge, so skip it
        end else if (busy) begin
            if (wait_left == 2'd0) begin
                busy      <= 1'b0;
                mem_ready <= 1'b1;
                if (mem_write) begin
                    stored[mem_addr] = mem_wdata;
                end else begin
                    mem_rdata <= line_value(mem_addr);
                end
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end else if (mem_read || mem_write) begin
            lcg_step  = lcg_next(lcg_state);
            lcg_state <= lcg_step;
            wait_left <= lcg_step[17:16];
            busy      <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// Testbench clock and reset source; 8 ns clock, reset held low for two cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire
